// ==== common/npu_isa_pkg.sv ====
`default_nettype none

package npu_isa_pkg;

    // Field widths of the 80-bit instruction word
    localparam int WEIGHT_ADDR_W = 40;
    localparam int BUF_ADDR_W    = 24;
    localparam int ACC_ADDR_W    = 16;
    localparam int LEN_W         = 32;
    localparam int OP_W          = 8;
    localparam int INSTR_W       = 80;

    // Opcodes, every other byte value is illegal
    typedef enum logic [OP_W-1:0] {
        OP_LOAD_WEIGHT = 8'h08,
        OP_MATMUL      = 8'h20,
        OP_MATMUL_ACC  = 8'h22
    } op_t;

    // Weight tile load: opcode, weight buffer start, number of rows
    typedef struct packed {
        op_t                      op;
        logic [WEIGHT_ADDR_W-1:0] weight_addr;
        logic [LEN_W-1:0]         len;
    } weight_instr_t;

    // Matrix multiply: opcode, unified buffer start, accumulator start, beats
    typedef struct packed {
        op_t                   op;
        logic [BUF_ADDR_W-1:0] buf_addr;
        logic [ACC_ADDR_W-1:0] acc_addr;
        logic [LEN_W-1:0]      len;
    } matmul_instr_t;

    // Both views share the opcode in the top byte
    typedef union packed {
        weight_instr_t weight;
        matmul_instr_t matmul;
    } instr_u;

endpackage

`default_nettype wire

// ==== common/npu_ctrl_pkg.sv ====
`default_nettype none

package npu_ctrl_pkg;

    import npu_isa_pkg::*;

    // Systolic rows addressable by the row select
    localparam int ROW_SEL_W = 5;

    // Weight buffer read stream towards the systolic array
    typedef struct packed {
        logic                     rd_en;
        logic [WEIGHT_ADDR_W-1:0] addr;
        logic [ROW_SEL_W-1:0]     row_sel;
        // Last row of a tile or of the whole load
        logic                     tile_done;
    } weight_ctrl_t;

    // Unified buffer read and accumulator write stream
    typedef struct packed {
        logic                  rd_en;
        logic [BUF_ADDR_W-1:0] buf_addr;
        logic [ACC_ADDR_W-1:0] acc_addr;
        // Add onto the accumulator contents instead of overwriting
        logic                  accumulate;
        // First beat of an instruction only
        logic                  activate;
    } mm_ctrl_t;

endpackage

`default_nettype wire

// ==== rtl/npu_load_counter.sv ====
`default_nettype none

module npu_load_counter #(
    parameter int COUNTER_WIDTH = 32
) (
    input  wire logic                     clk_i,
    input  wire logic                     rstn_i,
    input  wire logic                     enable_i,
    input  wire logic                     load_i,
    input  wire logic [COUNTER_WIDTH-1:0] start_val_i,
    output logic      [COUNTER_WIDTH-1:0] count_val_o
);

    // Constant addend used while counting
    localparam logic [COUNTER_WIDTH-1:0] ONE = COUNTER_WIDTH'(1);

    // First stage of the addend pipe
    logic [COUNTER_WIDTH-1:0] pipe_d;
    logic [COUNTER_WIDTH-1:0] pipe_q;
    // Addend register directly in front of the adder
    logic [COUNTER_WIDTH-1:0] addend_q;
    logic [COUNTER_WIDTH-1:0] sum;
    logic [COUNTER_WIDTH-1:0] count_q;
    // Delayed load, clears the count one edge after load_i
    logic                     load_q;

    // Start value on a load, otherwise count by one
    assign pipe_d = load_i ? start_val_i : ONE;

    // Wide adder, both operands come straight from registers
    assign sum = count_q + addend_q;

    assign count_val_o = count_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pipe_q   <= '0;
            addend_q <= '0;
            load_q   <= 1'b0;
        end else if (enable_i) begin
            pipe_q   <= pipe_d;
            addend_q <= pipe_q;
            load_q   <= load_i;
        end
    end

    // Count register
    // The clear follows load_q even in a stalled cycle, the add waits for enable
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            count_q <= '0;
        end else if (load_q) begin
            count_q <= '0;
        end else if (enable_i) begin
            // Start value lands here on the edge after the clear
            count_q <= sum;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/npu_instr_dispatch.sv ====
`default_nettype none

module npu_instr_dispatch
    import npu_isa_pkg::*;
(
    input  wire logic          clk_i,
    input  wire logic          rstn_i,
    input  wire logic          enable_i,
    input  wire instr_u        instr_i,
    input  wire logic          instr_en_i,
    input  wire logic          weight_busy_i,
    input  wire logic          mm_busy_i,
    output logic               weight_start_o,
    output weight_instr_t      weight_instr_o,
    output logic               mm_start_o,
    output matmul_instr_t      mm_instr_o,
    output logic               reject_o,
    output logic               illegal_o
);

    op_t  op;
    logic is_weight;
    logic is_mm;
    logic weight_accept;
    logic mm_accept;
    logic busy_hit;
    logic unknown_op;

    // Opcode sits in the same byte for both views
    assign op = instr_i.weight.op;

    always_comb begin
        is_weight = 1'b0;
        is_mm     = 1'b0;
        case (op)
            OP_LOAD_WEIGHT: is_weight = 1'b1;
            OP_MATMUL,
            OP_MATMUL_ACC:  is_mm     = 1'b1;
            default:        ;
        endcase
    end

    // Accept only into an idle unit, nothing is queued
    assign weight_accept = instr_en_i && is_weight && !weight_busy_i;
    assign mm_accept     = instr_en_i && is_mm && !mm_busy_i;

    // Legal opcode but its target still running
    assign busy_hit   = instr_en_i && ((is_weight && weight_busy_i) || (is_mm && mm_busy_i));
    assign unknown_op = instr_en_i && !is_weight && !is_mm;

    // One-cycle pulses, held as they are while stalled
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            weight_start_o <= 1'b0;
            mm_start_o     <= 1'b0;
            reject_o       <= 1'b0;
            illegal_o      <= 1'b0;
        end else if (enable_i) begin
            weight_start_o <= weight_accept;
            mm_start_o     <= mm_accept;
            reject_o       <= busy_hit;
            illegal_o      <= unknown_op;
        end
    end

    // Decoded fields for the sequencers, valid alongside the start pulse
    always_ff @(posedge clk_i) begin
        if (enable_i && weight_accept) begin
            weight_instr_o <= instr_i.weight;
        end
        if (enable_i && mm_accept) begin
            mm_instr_o <= instr_i.matmul;
        end
    end

endmodule

`default_nettype wire

// ==== weight_control/npu_weight_control.sv ====
`default_nettype none

module npu_weight_control
    import npu_isa_pkg::*;
    import npu_ctrl_pkg::*;
#(
    parameter int MATRIX_WIDTH = 14
) (
    input  wire logic          clk_i,
    input  wire logic          rstn_i,
    input  wire logic          enable_i,
    input  wire logic          start_i,
    input  wire weight_instr_t instr_i,
    output logic               busy_o,
    output weight_ctrl_t       ctrl_o
);

    // Row at which the row select wraps back to zero
    localparam logic [ROW_SEL_W-1:0] ROW_LAST = ROW_SEL_W'(MATRIX_WIDTH - 1);
    localparam logic [LEN_W-1:0]     LEN_ONE  = LEN_W'(1);

    logic [WEIGHT_ADDR_W-1:0] addr;
    // Start pulse delayed to line up with the counter output
    logic [1:0]               lead_q;
    // Rows still to be emitted
    logic [LEN_W-1:0]         rem_q;
    logic [ROW_SEL_W-1:0]     row_q;
    logic                     rd_en_q;
    logic                     busy_q;
    logic                     last_beat;

    // Address stream starting at the weight buffer address
    npu_load_counter #(
        .COUNTER_WIDTH(WEIGHT_ADDR_W)
    ) addr_cnt_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .enable_i    (enable_i),
        .load_i      (start_i),
        .start_val_i (instr_i.weight_addr),
        .count_val_o (addr)
    );

    assign last_beat = rd_en_q && (rem_q == LEN_ONE);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            lead_q  <= '0;
            rem_q   <= '0;
            row_q   <= '0;
            rd_en_q <= 1'b0;
            busy_q  <= 1'b0;
        end else if (enable_i) begin
            lead_q <= {lead_q[0], start_i};

            if (start_i) begin
                rem_q <= instr_i.len;
            end else if (rd_en_q) begin
                rem_q <= rem_q - LEN_ONE;
            end

            // Zero-length loads never go busy past the start cycle
            if (start_i) begin
                busy_q <= (instr_i.len != '0);
            end else if (last_beat) begin
                busy_q <= 1'b0;
            end

            // Counter shows the start address two edges after the load
            if (lead_q[1]) begin
                rd_en_q <= (rem_q != '0);
            end else if (last_beat) begin
                rd_en_q <= 1'b0;
            end

            if (start_i) begin
                row_q <= '0;
            end else if (rd_en_q) begin
                row_q <= (row_q == ROW_LAST) ? '0 : row_q + 1'b1;
            end
        end
    end

    // Start pulse counts as busy so a strobe right behind it is rejected
    assign busy_o = busy_q || start_i;

    assign ctrl_o.rd_en     = rd_en_q;
    assign ctrl_o.addr      = addr;
    assign ctrl_o.row_sel   = row_q;
    assign ctrl_o.tile_done = rd_en_q && ((row_q == ROW_LAST) || (rem_q == LEN_ONE));

endmodule

`default_nettype wire

// ==== matmul_control/npu_matmul_control.sv ====
`default_nettype none

module npu_matmul_control
    import npu_isa_pkg::*;
    import npu_ctrl_pkg::*;
(
    input  wire logic          clk_i,
    input  wire logic          rstn_i,
    input  wire logic          enable_i,
    input  wire logic          start_i,
    input  wire matmul_instr_t instr_i,
    output logic               busy_o,
    output mm_ctrl_t           ctrl_o
);

    localparam logic [LEN_W-1:0] LEN_ONE = LEN_W'(1);

    logic [BUF_ADDR_W-1:0] buf_addr;
    logic [ACC_ADDR_W-1:0] acc_addr;
    // Start pulse delayed to match the counter latency
    logic [1:0]            lead_q;
    logic [LEN_W-1:0]      rem_q;
    logic                  rd_en_q;
    logic                  busy_q;
    // Accumulate mode latched from the opcode
    logic                  acc_q;
    // Marks the first beat of the current instruction
    logic                  first_q;
    logic                  last_beat;

    // Unified buffer read addresses
    npu_load_counter #(
        .COUNTER_WIDTH(BUF_ADDR_W)
    ) buf_cnt_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .enable_i    (enable_i),
        .load_i      (start_i),
        .start_val_i (instr_i.buf_addr),
        .count_val_o (buf_addr)
    );

    // Accumulator write addresses, same load so both advance in lockstep
    npu_load_counter #(
        .COUNTER_WIDTH(ACC_ADDR_W)
    ) acc_cnt_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .enable_i    (enable_i),
        .load_i      (start_i),
        .start_val_i (instr_i.acc_addr),
        .count_val_o (acc_addr)
    );

    assign last_beat = rd_en_q && (rem_q == LEN_ONE);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            lead_q  <= '0;
            rem_q   <= '0;
            rd_en_q <= 1'b0;
            busy_q  <= 1'b0;
            acc_q   <= 1'b0;
            first_q <= 1'b0;
        end else if (enable_i) begin
            lead_q <= {lead_q[0], start_i};

            if (start_i) begin
                rem_q <= instr_i.len;
                acc_q <= (instr_i.op == OP_MATMUL_ACC);
            end else if (rd_en_q) begin
                rem_q <= rem_q - LEN_ONE;
            end

            if (start_i) begin
                busy_q <= (instr_i.len != '0);
            end else if (last_beat) begin
                busy_q <= 1'b0;
            end

            // First beat lines up with the start address on both counters
            if (lead_q[1]) begin
                rd_en_q <= (rem_q != '0);
            end else if (last_beat) begin
                rd_en_q <= 1'b0;
            end

            first_q <= lead_q[1];
        end
    end

    // Busy from the start pulse on, so back-to-back strobes are rejected
    assign busy_o = busy_q || start_i;

    assign ctrl_o.rd_en      = rd_en_q;
    assign ctrl_o.buf_addr   = buf_addr;
    assign ctrl_o.acc_addr   = acc_addr;
    assign ctrl_o.accumulate = acc_q;
    assign ctrl_o.activate   = rd_en_q && first_q;

endmodule

`default_nettype wire

// ==== rtl/npu_ctrl_top.sv ====
`default_nettype none

module npu_ctrl_top
    import npu_isa_pkg::*;
    import npu_ctrl_pkg::*;
#(
    parameter int MATRIX_WIDTH = 14
) (
    input  wire logic   clk_i,
    input  wire logic   rstn_i,
    input  wire logic   enable_i,
    input  wire instr_u instr_i,
    input  wire logic   instr_en_i,
    output weight_ctrl_t weight_ctrl_o,
    output mm_ctrl_t     mm_ctrl_o,
    output logic         weight_busy_o,
    output logic         mm_busy_o,
    output logic         reject_o,
    output logic         illegal_o
);

    // Dispatcher to sequencer handoff
    logic          weight_start;
    weight_instr_t weight_instr;
    logic          mm_start;
    matmul_instr_t mm_instr;

    npu_instr_dispatch dispatch_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .enable_i       (enable_i),
        .instr_i        (instr_i),
        .instr_en_i     (instr_en_i),
        .weight_busy_i  (weight_busy_o),
        .mm_busy_i      (mm_busy_o),
        .weight_start_o (weight_start),
        .weight_instr_o (weight_instr),
        .mm_start_o     (mm_start),
        .mm_instr_o     (mm_instr),
        .reject_o       (reject_o),
        .illegal_o      (illegal_o)
    );

    npu_weight_control #(
        .MATRIX_WIDTH(MATRIX_WIDTH)
    ) weight_ctrl_inst (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .enable_i (enable_i),
        .start_i  (weight_start),
        .instr_i  (weight_instr),
        .busy_o   (weight_busy_o),
        .ctrl_o   (weight_ctrl_o)
    );

    npu_matmul_control mm_ctrl_inst (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .enable_i (enable_i),
        .start_i  (mm_start),
        .instr_i  (mm_instr),
        .busy_o   (mm_busy_o),
        .ctrl_o   (mm_ctrl_o)
    );

endmodule

`default_nettype wire

// ==== dv/npu_ctrl_props.sv ====
`default_nettype none

module npu_ctrl_props
    import npu_ctrl_pkg::*;
(
    input wire logic         clk_i,
    input wire logic         rstn_i,
    input wire weight_ctrl_t weight_ctrl_o,
    input wire mm_ctrl_t     mm_ctrl_o,
    input wire logic         weight_busy_o,
    input wire logic         mm_busy_o,
    input wire logic         reject_o,
    input wire logic         illegal_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // No weight reads outside a busy window
    weight_rd_in_busy: assert property (
        @(posedge clk_i) disable iff (!rstn_i) weight_ctrl_o.rd_en |-> weight_busy_o
    ) else $error("weight read enable high while weight unit idle");

    mm_rd_in_busy: assert property (
        @(posedge clk_i) disable iff (!rstn_i) mm_ctrl_o.rd_en |-> mm_busy_o
    ) else $error("matmul read enable high while matmul unit idle");

    // A strobe is rejected or illegal but never both
    pulse_exclusive: assert property (
        @(posedge clk_i) disable iff (!rstn_i) !(reject_o && illegal_o)
    ) else $error("reject and illegal pulses high in the same cycle");

endmodule

bind npu_ctrl_top npu_ctrl_props props_inst (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .weight_ctrl_o (weight_ctrl_o),
    .mm_ctrl_o     (mm_ctrl_o),
    .weight_busy_o (weight_busy_o),
    .mm_busy_o     (mm_busy_o),
    .reject_o      (reject_o),
    .illegal_o     (illegal_o)
);

`default_nettype wire

// ==== dv/npu_ctrl_tb.sv ====
`default_nettype none

module npu_ctrl_tb
    import npu_isa_pkg::*;
    import npu_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MATRIX_WIDTH = 14;

    typedef enum int {ACCEPT, REJECT, ILLEGAL} outcome_e;

    // One strobe with its word, enabled cycles up to the next strobe, outcome and gap stalls
    typedef struct {
        instr_u   word;
        int       gap;
        outcome_e cls;
        bit       stall;
    } entry_t;

    logic         clk_i;
    logic         rstn_i;
    logic         enable_i;
    instr_u       instr_i;
    logic         instr_en_i;
    weight_ctrl_t weight_ctrl_o;
    mm_ctrl_t     mm_ctrl_o;
    logic         weight_busy_o;
    logic         mm_busy_o;
    logic         reject_o;
    logic         illegal_o;

    entry_t table_q[$];
    integer seed = 32'h2260_38ed;
    int     checks;
    int     errors;
    int     wd_cycles;
    // Enabled cycles seen so far give the time base of every expectation
    int     ecnt;
    int     next_idx;
    bit     stalling;

    // Instruction running in each unit
    int                       w_idx = -100;
    logic [WEIGHT_ADDR_W-1:0] w_addr;
    int                       w_len;
    int                       m_idx = -100;
    logic [BUF_ADDR_W-1:0]    m_buf;
    logic [ACC_ADDR_W-1:0]    m_acc;
    int                       m_len;
    bit                       m_accum;
    // Enabled cycle indices where a pulse is due
    bit                       rej_at[int];
    bit                       ill_at[int];
    // Previous sample for the freeze check
    weight_ctrl_t             prev_w;
    mm_ctrl_t                 prev_m;
    // Busy levels and pulses in the previous sample
    logic [3:0]               prev_lvl;
    bit                       prev_en = 1'b1;

    npu_ctrl_top #(
        .MATRIX_WIDTH(MATRIX_WIDTH)
    ) npu_ctrl_top_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .enable_i      (enable_i),
        .instr_i       (instr_i),
        .instr_en_i    (instr_en_i),
        .weight_ctrl_o (weight_ctrl_o),
        .mm_ctrl_o     (mm_ctrl_o),
        .weight_busy_o (weight_busy_o),
        .mm_busy_o     (mm_busy_o),
        .reject_o      (reject_o),
        .illegal_o     (illegal_o)
    );

    always #10 clk_i = ~clk_i;

    function automatic instr_u weight_word(logic [WEIGHT_ADDR_W-1:0] addr, int len);
        instr_u w;
        w.weight.op          = OP_LOAD_WEIGHT;
        w.weight.weight_addr = addr;
        w.weight.len         = LEN_W'(len);
        return w;
    endfunction

    function automatic instr_u mm_word(op_t op, logic [BUF_ADDR_W-1:0] buf_a,
                                       logic [ACC_ADDR_W-1:0] acc_a, int len);
        instr_u w;
        w.matmul.op       = op;
        w.matmul.buf_addr = buf_a;
        w.matmul.acc_addr = acc_a;
        w.matmul.len      = LEN_W'(len);
        return w;
    endfunction

    // Any opcode byte with the rest of the word zero
    function automatic instr_u raw_word(logic [7:0] op);
        instr_u w;
        w = {op, 72'd0};
        return w;
    endfunction

    task automatic add_entry(instr_u word, int gap, outcome_e cls, bit stall);
        entry_t e;
        e.word  = word;
        e.gap   = gap;
        e.cls   = cls;
        e.stall = stall;
        table_q.push_back(e);
        // Length is the low field in both views
        wd_cycles += 4 * (int'(word.weight.len) + gap);
    endtask

    task automatic build_table();
        add_entry(weight_word(40'h12_3456_7FF0, 30), 2, ACCEPT, 1'b0);
        // Weight unit busy so the stream above must run on untouched
        add_entry(weight_word(40'h00_0000_0100, 5), 3, REJECT, 1'b0);
        // Matmul alongside the weight load
        add_entry(mm_word(OP_MATMUL, 24'h00_1F00, 16'h0040, 8), 3, ACCEPT, 1'b0);
        add_entry(raw_word(8'h55), 2, ILLEGAL, 1'b0);
        add_entry(mm_word(OP_MATMUL_ACC, 24'h00_0010, 16'h0001, 4), 1, REJECT, 1'b0);
        add_entry(weight_word(40'h00_0000_0200, 3), 30, REJECT, 1'b0);
        // From here on the gaps carry random stalls and addresses wrap
        add_entry(mm_word(OP_MATMUL_ACC, 24'hFF_FFFC, 16'hFFFE, 6), 1, ACCEPT, 1'b1);
        add_entry(weight_word(40'hFF_FFFF_FFF8, 16), 25, ACCEPT, 1'b1);
        add_entry(weight_word(40'h00_0000_0300, 0), 4, ACCEPT, 1'b1);
        add_entry(mm_word(OP_MATMUL, 24'h00_0400, 16'h0200, 1), 3, ACCEPT, 1'b1);
        add_entry(weight_word(40'h00_0000_0500, 2), 10, ACCEPT, 1'b1);
        add_entry(raw_word(8'h00), 12, ILLEGAL, 1'b0);
    endtask

    // First beat four enabled edges after the strobe and then one per cycle
    function automatic weight_ctrl_t model_weight(int i);
        weight_ctrl_t e;
        int k;
        e = '0;
        k = i - w_idx - 4;
        if (k >= 0 && k < w_len) begin
            e.rd_en     = 1'b1;
            e.addr      = w_addr + WEIGHT_ADDR_W'(k);
            e.row_sel   = ROW_SEL_W'(k % MATRIX_WIDTH);
            e.tile_done = (k % MATRIX_WIDTH == MATRIX_WIDTH - 1) || (k == w_len - 1);
        end
        return e;
    endfunction

    function automatic mm_ctrl_t model_mm(int i);
        mm_ctrl_t e;
        int k;
        e = '0;
        k = i - m_idx - 4;
        if (k >= 0 && k < m_len) begin
            e.rd_en      = 1'b1;
            e.buf_addr   = m_buf + BUF_ADDR_W'(k);
            e.acc_addr   = m_acc + ACC_ADDR_W'(k);
            e.accumulate = m_accum;
            e.activate   = (k == 0);
        end
        return e;
    endfunction

    // Busy from the edge after the strobe until the last beat is taken
    function automatic bit busy_model(int i, int idx, int len);
        return (i == idx + 1) || (len > 0 && i > idx && i <= idx + 3 + len);
    endfunction

    task automatic compare_weight(string name, weight_ctrl_t exp, weight_ctrl_t act);
        weight_ctrl_t a;
        a = act;
        // Address and row are don't-care between beats
        if (!exp.rd_en) begin
            a.addr    = exp.addr;
            a.row_sel = exp.row_sel;
        end
        checks++;
        if (a !== exp) begin
            errors++;
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_mm(string name, mm_ctrl_t exp, mm_ctrl_t act);
        mm_ctrl_t a;
        a = act;
        if (!exp.rd_en) begin
            a.buf_addr   = exp.buf_addr;
            a.acc_addr   = exp.acc_addr;
            a.accumulate = exp.accumulate;
        end
        checks++;
        if (a !== exp) begin
            errors++;
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_level(string name, bit exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // Sampled mid-cycle where the state is taken by the next edge when enabled
    always @(negedge clk_i) begin
        if (rstn_i) begin
            // Nothing may have moved across a stalled edge
            if (!prev_en) begin
                compare_weight("weight_ctrl_o frozen", prev_w, weight_ctrl_o);
                compare_mm("mm_ctrl_o frozen", prev_m, mm_ctrl_o);
                check_level("weight_busy_o frozen", prev_lvl[3], weight_busy_o);
                check_level("mm_busy_o frozen", prev_lvl[2], mm_busy_o);
                check_level("reject_o frozen", prev_lvl[1], reject_o);
                check_level("illegal_o frozen", prev_lvl[0], illegal_o);
            end
            if (enable_i) begin
                compare_weight("weight_ctrl_o", model_weight(ecnt), weight_ctrl_o);
                compare_mm("mm_ctrl_o", model_mm(ecnt), mm_ctrl_o);
                check_level("weight_busy_o", busy_model(ecnt, w_idx, w_len), weight_busy_o);
                check_level("mm_busy_o", busy_model(ecnt, m_idx, m_len), mm_busy_o);
                check_level("reject_o", rej_at.exists(ecnt) != 0, reject_o);
                check_level("illegal_o", ill_at.exists(ecnt) != 0, illegal_o);
                ecnt++;
            end
            prev_w   = weight_ctrl_o;
            prev_m   = mm_ctrl_o;
            prev_lvl = {weight_busy_o, mm_busy_o, reject_o, illegal_o};
            prev_en  = enable_i;
        end
    end

    // Idle cycles until the enabled cycle count reaches the next strobe slot
    task automatic wait_slot();
        @(posedge clk_i);
        #2;
        while (ecnt < next_idx) begin
            instr_en_i = 1'b0;
            instr_i    = '0;
            enable_i   = stalling ? (($random(seed) & 3) != 0) : 1'b1;
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic drive_entry(entry_t e);
        int n;
        wait_slot();
        n = ecnt;
        // Strobe cycle is always enabled so the dispatcher takes it
        enable_i   = 1'b1;
        instr_en_i = 1'b1;
        instr_i    = e.word;
        case (e.cls)
            ACCEPT: begin
                if (e.word.weight.op == OP_LOAD_WEIGHT) begin
                    w_idx  = n;
                    w_addr = e.word.weight.weight_addr;
                    w_len  = int'(e.word.weight.len);
                end else begin
                    m_idx   = n;
                    m_buf   = e.word.matmul.buf_addr;
                    m_acc   = e.word.matmul.acc_addr;
                    m_len   = int'(e.word.matmul.len);
                    m_accum = (e.word.matmul.op == OP_MATMUL_ACC);
                end
            end
            REJECT:  rej_at[n + 1] = 1'b1;
            default: ill_at[n + 1] = 1'b1;
        endcase
        next_idx = n + e.gap;
        stalling = e.stall;
    endtask

    initial begin
        clk_i      = 1'b0;
        rstn_i     = 1'b0;
        enable_i   = 1'b0;
        instr_en_i = 1'b0;
        instr_i    = '0;
        build_table();
        repeat (10) @(posedge clk_i);
        #2;
        rstn_i   = 1'b1;
        enable_i = 1'b1;
        foreach (table_q[j]) begin
            drive_entry(table_q[j]);
        end
        // Drain the last gap so every tail beat gets checked
        wait_slot();
        instr_en_i = 1'b0;
        enable_i   = 1'b1;
        repeat (2) @(posedge clk_i);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog whose limit scales with table lengths and gaps
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles + 20) @(posedge clk_i);
        $display("Timeout: stimulus did not finish within %0d cycles", wd_cycles + 20);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
common/npu_isa_pkg.sv
common/npu_ctrl_pkg.sv
rtl/npu_load_counter.sv
rtl/npu_instr_dispatch.sv
weight_control/npu_weight_control.sv
matmul_control/npu_matmul_control.sv
rtl/npu_ctrl_top.sv
dv/npu_ctrl_props.sv
dv/npu_ctrl_tb.sv

// ==== Makefile ====
TOP := npu_ctrl_tb
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
